// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= tb_turfio_cmd_timing
RTL_TOP   ?= turfio_cmd_timing
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

FAIL_MSG := TEST FAIL
PASS_MSG := TEST PASS
SIM_BIN  := $(OBJ_DIR)/V$(TB_TOP)
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

# Lint the design alone, then with the testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# Result comes from the log, a stopped run has no pass line
sim: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation stopped without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/sync_sequencer.sv
`timescale 1ns/1ps

module sync_sequencer (
    input  logic sysclk_i,
    input  logic reset_i,
    input  logic sync_req_i,
    input  logic run_reset_i,
    input  logic run_stop_i,
    input  logic en_ext_sync_i,
    input  logic offset_done_i,
    output logic arm_o,
    output logic realign_o,
    output logic aligned_o,
    output logic run_active_o
);
    import turfio_timing_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;

    // Sync request that actually starts an alignment
    logic sync_accept;

    // Ignored when external sync is off or already waiting
    assign sync_accept = sync_req_i && en_ext_sync_i && (state_q != ARMED);

    // Countdown finished while armed, phase restarts this cycle
    assign realign_o = (state_q == ARMED) && offset_done_i;

    // Level used to enable sync outputs
    assign aligned_o = (state_q == ALIGNED);

    ////////////////////////////////////////////////////////////
    // Alignment FSM
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (sync_accept) begin
                    state_d = ARMED;
                end
            end
            ARMED: begin
                // Wait for the offset countdown
                if (offset_done_i) begin
                    state_d = ALIGNED;
                end
            end
            ALIGNED: begin
                // A new request re-arms and drops alignment
                if (sync_accept) begin
                    state_d = ARMED;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            arm_o   <= 1'b0;
        end else begin
            state_q <= state_d;
            // Arm pulse loads the countdown one cycle later
            arm_o   <= sync_accept;
        end
    end

    // Run flag, set by reset command and cleared by stop
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            run_active_o <= 1'b0;
        end else if (run_reset_i) begin
            run_active_o <= 1'b1;
        end else if (run_stop_i) begin
            run_active_o <= 1'b0;
        end
    end

endmodule

// File: source/sysclk_timebase.sv
`timescale 1ns/1ps

module sysclk_timebase #(
    parameter int COUNT_BITS = turfio_timing_pkg::COUNT_BITS_DEF,
    parameter int PHASE_BITS = turfio_timing_pkg::PHASE_BITS_DEF
) (
    input  logic                                   sysclk_i,
    input  logic                                   reset_i,
    input  logic                                   run_reset_i,
    input  logic                                   pps_i,
    input  logic                                   arm_i,
    input  logic                                   realign_i,
    input  logic                                   aligned_i,
    input  logic [turfio_timing_pkg::OFFSET_BITS-1:0] sync_offset_i,
    input  logic [turfio_timing_pkg::OFFSET_BITS-1:0] clock_offset_i,
    output logic                                   offset_done_o,
    output logic                                   sync_o,
    output logic                                   clk_sync_o,
    output logic [COUNT_BITS-1:0]                  sysclk_count_o,
    output logic [COUNT_BITS-1:0]                  pps_time_o
);
    import turfio_timing_pkg::*;

    // Position inside the sync period
    logic [PHASE_BITS-1:0]  phase_q;

    // Sync offset countdown
    logic [OFFSET_BITS-1:0] countdown_q;
    logic                   counting_q;

    // Count captured at the last PPS
    logic [COUNT_BITS-1:0]  pps_hold_q;

    ////////////////////////////////////////////////////////////
    // Phase and clock count
    ////////////////////////////////////////////////////////////

    // Free running, forced to zero on realign
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            phase_q <= '0;
        end else if (realign_i) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    // Run reset loads the clock offset, shown two edges after the command
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            sysclk_count_o <= '0;
        end else if (run_reset_i) begin
            sysclk_count_o <= COUNT_BITS'(clock_offset_i);
        end else begin
            sysclk_count_o <= sysclk_count_o + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Sync offset countdown
    ////////////////////////////////////////////////////////////

    // Zero offset expires in the cycle right after arm
    assign offset_done_o = counting_q && (countdown_q == '0);

    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            counting_q <= 1'b0;
        end else if (arm_i) begin
            counting_q <= 1'b1;
        end else if (offset_done_o) begin
            counting_q <= 1'b0;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (arm_i) begin
            countdown_q <= sync_offset_i;
        end else if (counting_q && !offset_done_o) begin
            countdown_q <= countdown_q - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // PPS capture and sync outputs
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk_i) begin
        if (pps_i) begin
            pps_hold_q <= sysclk_count_o;
        end
    end

    // Live count during the PPS cycle, held value after it
    assign pps_time_o = pps_i ? sysclk_count_o : pps_hold_q;

    // First cycle of each period
    assign sync_o     = aligned_i && (phase_q == '0);
    // High for the first half of each period
    assign clk_sync_o = aligned_i && !phase_q[PHASE_BITS-1];

endmodule

// File: source/turf_command_decoder.sv
`timescale 1ns/1ps

module turf_command_decoder (
    input  logic                                      sysclk_i,
    input  logic                                      reset_i,
    input  logic [31:0]                               command_i,
    input  logic                                      command_valid_i,
    input  logic                                      run_active_i,
    output logic                                      sync_req_o,
    output logic                                      run_reset_o,
    output logic                                      run_stop_o,
    output logic                                      pps_o,
    output logic [turfio_cmd_pkg::TRIG_TIME_BITS-1:0] trig_time_o,
    output logic                                      trig_time_valid_o
);
    import turfio_cmd_pkg::*;

    // Incoming word seen through both views
    turf_cmd_u cmd;

    // Next-cycle event flags
    logic sync_d;
    logic reset_d;
    logic stop_d;
    logic pps_d;
    logic trig_d;

    assign cmd = command_i;

    ////////////////////////////////////////////////////////////
    // Word decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        sync_d  = 1'b0;
        reset_d = 1'b0;
        stop_d  = 1'b0;
        pps_d   = 1'b0;
        trig_d  = 1'b0;
        if (command_valid_i) begin
            // Run view gives type and run code
            case (cmd.run.cmd_type)
                CMD_RUN: begin
                    case (cmd.run.run_code)
                        RUN_SYNC:  sync_d  = 1'b1;
                        RUN_RESET: reset_d = 1'b1;
                        RUN_STOP:  stop_d  = 1'b1;
                        default:   ;
                    endcase
                end
                CMD_PPS: pps_d = 1'b1;
                default: ;
            endcase
            // Trigger view, only honored during a run
            trig_d = (cmd.trig.cmd_type == CMD_TRIG) && run_active_i;
        end
    end

    // One-cycle event pulses
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            sync_req_o        <= 1'b0;
            run_reset_o       <= 1'b0;
            run_stop_o        <= 1'b0;
            pps_o             <= 1'b0;
            trig_time_valid_o <= 1'b0;
        end else begin
            sync_req_o        <= sync_d;
            run_reset_o       <= reset_d;
            run_stop_o        <= stop_d;
            pps_o             <= pps_d;
            trig_time_valid_o <= trig_d;
        end
    end

    // Trigger time held until the next accepted trigger
    always_ff @(posedge sysclk_i) begin
        if (trig_d) begin
            trig_time_o <= cmd.trig.trig_time;
        end
    end

endmodule

// File: source/turfio_cmd_pkg.sv
package turfio_cmd_pkg;

    // Width of the trigger time field
    localparam int TRIG_TIME_BITS = 15;

    // Type field in bits 31:30 of every command word
    typedef enum logic [1:0] {
        CMD_IDLE = 2'd0,
        CMD_RUN  = 2'd1,
        CMD_TRIG = 2'd2,
        CMD_PPS  = 2'd3
    } cmd_type_e;

    // Run code in bits 1:0 of a run command
    typedef enum logic [1:0] {
        RUN_NONE  = 2'd0,
        RUN_SYNC  = 2'd1,
        RUN_RESET = 2'd2,
        RUN_STOP  = 2'd3
    } run_code_e;

    ////////////////////////////////////////////////////////////
    // Two views of the same 32-bit command word
    ////////////////////////////////////////////////////////////

    // Run command layout
    typedef struct packed {
        cmd_type_e   cmd_type;
        logic [27:0] unused;
        run_code_e   run_code;
    } run_view_t;

    // Trigger layout, time in the low 15 bits
    typedef struct packed {
        cmd_type_e                 cmd_type;
        logic [31-2-TRIG_TIME_BITS:0] unused;
        logic [TRIG_TIME_BITS-1:0] trig_time;
    } trig_view_t;

    // Both views share the type field position
    typedef union packed {
        run_view_t  run;
        trig_view_t trig;
    } turf_cmd_u;

endpackage

// File: source/turfio_cmd_timing.sv
`timescale 1ns/1ps

module turfio_cmd_timing #(
    parameter int COUNT_BITS = turfio_timing_pkg::COUNT_BITS_DEF,
    parameter int PHASE_BITS = turfio_timing_pkg::PHASE_BITS_DEF
) (
    input  logic                                      sysclk_i,
    input  logic                                      reset_i,
    input  logic [31:0]                               command_i,
    input  logic                                      command_valid_i,
    input  logic                                      en_ext_sync_i,
    input  logic [turfio_timing_pkg::OFFSET_BITS-1:0] sync_offset_i,
    input  logic [turfio_timing_pkg::OFFSET_BITS-1:0] clock_offset_i,
    output logic                                      run_sync_o,
    output logic                                      run_stop_o,
    output logic                                      pps_o,
    output logic [turfio_cmd_pkg::TRIG_TIME_BITS-1:0] trig_time_o,
    output logic                                      trig_time_valid_o,
    output logic                                      run_active_o,
    output logic                                      sync_o,
    output logic                                      clk_sync_o,
    output logic [COUNT_BITS-1:0]                     sysclk_count_o,
    output logic [COUNT_BITS-1:0]                     pps_time_o
);

    // Decoder to timebase and sequencer
    logic run_reset;
    // Sequencer to timebase
    logic arm;
    logic realign;
    logic aligned;
    // Timebase back to sequencer
    logic offset_done;

    ////////////////////////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////////////////////////
    turf_command_decoder u_decoder (
        .sysclk_i          (sysclk_i),
        .reset_i           (reset_i),
        .command_i         (command_i),
        .command_valid_i   (command_valid_i),
        .run_active_i      (run_active_o),
        .sync_req_o        (run_sync_o),
        .run_reset_o       (run_reset),
        .run_stop_o        (run_stop_o),
        .pps_o             (pps_o),
        .trig_time_o       (trig_time_o),
        .trig_time_valid_o (trig_time_valid_o)
    );

    // Sync alignment and run state
    sync_sequencer u_sequencer (
        .sysclk_i      (sysclk_i),
        .reset_i       (reset_i),
        .sync_req_i    (run_sync_o),
        .run_reset_i   (run_reset),
        .run_stop_i    (run_stop_o),
        .en_ext_sync_i (en_ext_sync_i),
        .offset_done_i (offset_done),
        .arm_o         (arm),
        .realign_o     (realign),
        .aligned_o     (aligned),
        .run_active_o  (run_active_o)
    );

    ////////////////////////////////////////////////////////////
    // Clock count and sync timing
    ////////////////////////////////////////////////////////////
    sysclk_timebase #(
        .COUNT_BITS (COUNT_BITS),
        .PHASE_BITS (PHASE_BITS)
    ) u_timebase (
        .sysclk_i       (sysclk_i),
        .reset_i        (reset_i),
        .run_reset_i    (run_reset),
        .pps_i          (pps_o),
        .arm_i          (arm),
        .realign_i      (realign),
        .aligned_i      (aligned),
        .sync_offset_i  (sync_offset_i),
        .clock_offset_i (clock_offset_i),
        .offset_done_o  (offset_done),
        .sync_o         (sync_o),
        .clk_sync_o     (clk_sync_o),
        .sysclk_count_o (sysclk_count_o),
        .pps_time_o     (pps_time_o)
    );

endmodule

// File: source/turfio_timing_pkg.sv
package turfio_timing_pkg;

    // Default width of the sysclk count
    localparam int COUNT_BITS_DEF = 48;

    // Default phase width, 16-cycle sync period
    localparam int PHASE_BITS_DEF = 4;

    // Width of the sync and clock offsets
    localparam int OFFSET_BITS = 8;

    ////////////////////////////////////////////////////////////
    // Sync sequencer states
    ////////////////////////////////////////////////////////////

    // IDLE    no alignment yet
    // ARMED   waiting out the sync offset
    // ALIGNED phase locked to the last sync request
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ARMED   = 2'd1,
        ALIGNED = 2'd2
    } seq_state_e;

endpackage

// File: tb.f
source/turfio_cmd_pkg.sv
source/turfio_timing_pkg.sv
source/turf_command_decoder.sv
source/sync_sequencer.sv
source/sysclk_timebase.sv
source/turfio_cmd_timing.sv
testbench/tb_clock_gen.sv
testbench/turfio_cmd_timing_assertions.sv
testbench/tb_turfio_cmd_timing.sv

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);

    // Free running sysclk
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // Reset held over the first rising edges, released on an edge
    initial begin
        reset_o <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// File: testbench/tb_turfio_cmd_timing.sv
`timescale 1ns/1ps

module tb_turfio_cmd_timing;
    import turfio_cmd_pkg::*;
    import turfio_timing_pkg::*;

    // Directed tests need roughly 350 cycles, limit leaves margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int PERIOD         = 1 << PHASE_BITS_DEF;

    logic                      sysclk;
    logic                      reset;
    logic [31:0]               command;
    logic                      command_valid;
    logic                      en_ext_sync;
    logic [OFFSET_BITS-1:0]    sync_offset;
    logic [OFFSET_BITS-1:0]    clock_offset;
    logic                      run_sync;
    logic                      run_stop;
    logic                      pps;
    logic [TRIG_TIME_BITS-1:0] trig_time;
    logic                      trig_time_valid;
    logic                      run_active;
    logic                      sync;
    logic                      clk_sync;
    logic [COUNT_BITS_DEF-1:0] sysclk_count;
    logic [COUNT_BITS_DEF-1:0] pps_time;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state   = 32'h496e;

    tb_clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (5)
    ) u_clock_gen (
        .clk_o   (sysclk),
        .reset_o (reset)
    );

    turfio_cmd_timing #(
        .COUNT_BITS (COUNT_BITS_DEF),
        .PHASE_BITS (PHASE_BITS_DEF)
    ) dut0 (
        .sysclk_i          (sysclk),
        .reset_i           (reset),
        .command_i         (command),
        .command_valid_i   (command_valid),
        .en_ext_sync_i     (en_ext_sync),
        .sync_offset_i     (sync_offset),
        .clock_offset_i    (clock_offset),
        .run_sync_o        (run_sync),
        .run_stop_o        (run_stop),
        .pps_o             (pps),
        .trig_time_o       (trig_time),
        .trig_time_valid_o (trig_time_valid),
        .run_active_o      (run_active),
        .sync_o            (sync),
        .clk_sync_o        (clk_sync),
        .sysclk_count_o    (sysclk_count),
        .pps_time_o        (pps_time)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper bits of the LCG, the low ones repeat quickly
    task automatic draw_random(output logic [31:0] value);
        lcg_state = lcg_next(lcg_state);
        value     = {8'h00, lcg_state[31:8]};
    endtask

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    // Word is sampled on the rising edge after the drive edge
    task automatic send_command(input logic [31:0] word);
        @(posedge sysclk);
        command       <= word;
        command_valid <= 1'b1;
        @(posedge sysclk);
        command       <= 32'h0;
        command_valid <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset_state;
        @(negedge sysclk);
        while (reset === 1'b1) begin
            @(negedge sysclk);
        end
        check_equal(64'({run_sync, run_stop, pps, trig_time_valid}), 64'h0, "pulse after reset");
        check_equal(64'({run_active, sync, clk_sync}), 64'h0, "level after reset");
        check_equal(64'(sysclk_count), 64'h0, "count after reset");
    endtask

    task automatic test_idle_words;
        logic [31:0]               words [2];
        logic [COUNT_BITS_DEF-1:0] last_count;
        words[0] = 32'h0000_0000;
        // Run command with code 0
        words[1] = {2'd1, 28'h0, 2'd0};
        foreach (words[w]) begin
            send_command(words[w]);
            for (int i = 0; i < 4; i++) begin
                @(negedge sysclk);
                check_equal(64'({run_sync, run_stop, pps, trig_time_valid}), 64'h0,
                            "pulse from ignored word");
                if (i > 0) begin
                    check_equal(64'(sysclk_count), 64'(last_count + 1'b1), "count reloaded");
                end
                last_count = sysclk_count;
            end
        end
    endtask

    task automatic test_run_reset_stop;
        logic [31:0]               rnd;
        logic [COUNT_BITS_DEF-1:0] expected;
        draw_random(rnd);
        @(posedge sysclk);
        clock_offset <= rnd[OFFSET_BITS-1:0];
        send_command({2'd1, 28'h0, 2'd2});
        repeat (2) @(negedge sysclk);
        check_equal(64'(run_active), 64'h1, "run active after run reset");
        expected = COUNT_BITS_DEF'(rnd[OFFSET_BITS-1:0]);
        repeat (8) begin
            check_equal(64'(sysclk_count), 64'(expected), "clock count");
            expected = expected + 1'b1;
            @(negedge sysclk);
        end
        send_command({2'd1, 28'h0, 2'd3});
        @(negedge sysclk);
        check_equal(64'({run_stop, run_active}), 64'h3, "stop pulse, run still active");
        @(negedge sysclk);
        check_equal(64'(run_active), 64'h0, "run active after stop");
    endtask

    task automatic test_triggers;
        logic [31:0]               rnd;
        logic [TRIG_TIME_BITS-1:0] t;
        send_command({2'd1, 28'h0, 2'd2});
        repeat (2) @(negedge sysclk);
        check_equal(64'(run_active), 64'h1, "run active before triggers");
        repeat (20) begin
            draw_random(rnd);
            t = rnd[TRIG_TIME_BITS-1:0];
            send_command({2'd2, 15'h0, t});
            @(negedge sysclk);
            check_equal(64'(trig_time_valid), 64'h1, "trigger valid");
            check_equal(64'(trig_time), 64'(t), "trigger time");
            @(negedge sysclk);
            check_equal(64'(trig_time_valid), 64'h0, "trigger valid width");
        end
        send_command({2'd1, 28'h0, 2'd3});
        repeat (2) @(negedge sysclk);
        // Triggers outside a run are dropped
        repeat (5) begin
            draw_random(rnd);
            send_command({2'd2, 15'h0, rnd[TRIG_TIME_BITS-1:0]});
            repeat (2) begin
                @(negedge sysclk);
                check_equal(64'(trig_time_valid), 64'h0, "trigger after stop");
            end
        end
    endtask

    task automatic test_sync_disabled;
        @(posedge sysclk);
        en_ext_sync <= 1'b0;
        send_command({2'd1, 28'h0, 2'd1});
        @(negedge sysclk);
        check_equal(64'(run_sync), 64'h1, "run sync pulse");
        repeat (40) begin
            @(negedge sysclk);
            check_equal(64'(sync), 64'h0, "sync with external sync off");
        end
    endtask

    task automatic test_sync_aligned(input logic [OFFSET_BITS-1:0] offset);
        int first;
        @(posedge sysclk);
        en_ext_sync <= 1'b1;
        sync_offset <= offset;
        send_command({2'd1, 28'h0, 2'd1});
        first = 4 + int'(offset);
        // Edge k+1 may still show the previous alignment
        @(negedge sysclk);
        for (int i = 2; i < first + 3 * PERIOD; i++) begin
            @(negedge sysclk);
            if (i < first) begin
                check_equal(64'({sync, clk_sync}), 64'h0, "sync while armed");
            end else begin
                check_equal(64'(sync), 64'(((i - first) % PERIOD) == 0), "sync pulse");
                check_equal(64'(clk_sync), 64'(((i - first) % PERIOD) < PERIOD / 2),
                            "clk_sync level");
            end
        end
    endtask

    task automatic test_pps;
        logic [COUNT_BITS_DEF-1:0] expected;
        send_command({2'd1, 28'h0, 2'd2});
        @(negedge sysclk);
        // Count reloads on the PPS drive edge, one more in the pulse cycle
        expected = COUNT_BITS_DEF'(clock_offset) + 1'b1;
        send_command({2'd3, 30'h0});
        @(negedge sysclk);
        check_equal(64'(pps), 64'h1, "pps pulse");
        check_equal(64'(sysclk_count), 64'(expected), "count in pps cycle");
        check_equal(64'(pps_time), 64'(expected), "pps time in pulse cycle");
        @(negedge sysclk);
        check_equal(64'(pps), 64'h0, "pps pulse width");
        check_equal(64'(pps_time), 64'(expected), "pps time held");
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence and report
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] rnd;
        command       <= 32'h0;
        command_valid <= 1'b0;
        en_ext_sync   <= 1'b0;
        sync_offset   <= '0;
        clock_offset  <= '0;
        test_reset_state();
        test_idle_words();
        test_run_reset_stop();
        test_triggers();
        test_sync_disabled();
        test_sync_aligned('0);
        draw_random(rnd);
        test_sync_aligned(OFFSET_BITS'(rnd % 32'd40) + 1'b1);
        test_pps();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Run limit
    always @(posedge sysclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

endmodule

// File: testbench/turfio_cmd_timing_assertions.sv
`timescale 1ns/1ps

module turfio_cmd_timing_assertions #(
    parameter int PHASE_BITS = turfio_timing_pkg::PHASE_BITS_DEF
) (
    input logic sysclk_i,
    input logic reset_i,
    input logic run_sync_i,
    input logic run_stop_i,
    input logic pps_i,
    input logic trig_time_valid_i,
    input logic run_active_i,
    input logic aligned_i,
    input logic sync_i,
    input logic clk_sync_i
);

    localparam int PERIOD = 1 << PHASE_BITS;

    // Cycles since the last sync pulse, zero while not aligned
    logic [PHASE_BITS:0] gap_q;

    always_ff @(posedge sysclk_i) begin
        if (reset_i || !aligned_i) begin
            gap_q <= '0;
        end else if (sync_i) begin
            gap_q <= (PHASE_BITS + 1)'(1);
        end else if (gap_q != '0) begin
            gap_q <= gap_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Event pulses last one cycle
    ////////////////////////////////////////////////////////////
    run_sync_width: assert property (@(posedge sysclk_i) disable iff (reset_i)
        run_sync_i |=> !run_sync_i)
        else $error("run sync pulse longer than one cycle");

    run_stop_width: assert property (@(posedge sysclk_i) disable iff (reset_i)
        run_stop_i |=> !run_stop_i)
        else $error("run stop pulse longer than one cycle");

    pps_width: assert property (@(posedge sysclk_i) disable iff (reset_i)
        pps_i |=> !pps_i)
        else $error("pps pulse longer than one cycle");

    trig_width: assert property (@(posedge sysclk_i) disable iff (reset_i)
        trig_time_valid_i |=> !trig_time_valid_i)
        else $error("trigger valid longer than one cycle");

    ////////////////////////////////////////////////////////////
    // Sync period and trigger gating
    ////////////////////////////////////////////////////////////

    // Exactly one sync per period while alignment holds
    sync_period: assert property (@(posedge sysclk_i) disable iff (reset_i)
        (aligned_i && gap_q != '0) |-> (sync_i == (gap_q == (PHASE_BITS + 1)'(PERIOD))))
        else $error("sync pulse off its period");

    // High half starts at each sync pulse, counted from the gap
    clk_sync_half: assert property (@(posedge sysclk_i) disable iff (reset_i)
        (aligned_i && gap_q != '0)
            |-> (clk_sync_i == (gap_q == PERIOD || gap_q < PERIOD / 2)))
        else $error("clk_sync level off its half period");

    trig_gated: assert property (@(posedge sysclk_i) disable iff (reset_i)
        trig_time_valid_i |-> $past(run_active_i))
        else $error("trigger accepted outside a run");

endmodule

bind turfio_cmd_timing turfio_cmd_timing_assertions #(
    .PHASE_BITS (PHASE_BITS)
) u_assertions (
    .sysclk_i          (sysclk_i),
    .reset_i           (reset_i),
    .run_sync_i        (run_sync_o),
    .run_stop_i        (run_stop_o),
    .pps_i             (pps_o),
    .trig_time_valid_i (trig_time_valid_o),
    .run_active_i      (run_active_o),
    .aligned_i         (aligned),
    .sync_i            (sync_o),
    .clk_sync_i        (clk_sync_o)
);
